//--- bht.sv
/* branch history table of two-bit counters with valid bits
   read by the response PC, trained by resolved branches */
module bht #(
    parameter int unsigned BhtEntries = fetch_frontend_pkg::BHT_ENTRIES_DEF
) (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  fetch_frontend_pkg::addr_t pc_i,
    input  logic                      update_valid_i,
    input  fetch_frontend_pkg::addr_t update_pc_i,
    input  logic                      update_taken_i,
    output logic                      pred_valid_o,
    output logic                      pred_taken_o
);

    localparam int unsigned IdxW = (BhtEntries > 1) ? $clog2(BhtEntries) : 1;

    logic [1:0]            cnt_q [BhtEntries];
    logic [BhtEntries-1:0] valid_q;
    logic [IdxW-1:0]       rd_idx, wr_idx;
    logic [1:0]            cnt_upd;

    // word offset bits are skipped
    assign rd_idx = pc_i[IdxW+1:2];
    assign wr_idx = update_pc_i[IdxW+1:2];

    assign pred_valid_o = valid_q[rd_idx];
    // upper counter bit is the direction
    assign pred_taken_o = cnt_q[rd_idx][1];

    // ------------------------------
    // counter update
    // ------------------------------
    always_comb begin
        cnt_upd = cnt_q[wr_idx];
        if (!valid_q[wr_idx])
            // fresh entry starts weak in the resolved direction
            cnt_upd = update_taken_i ? 2'b10 : 2'b01;
        else if (update_taken_i && cnt_upd != 2'b11)
            cnt_upd = cnt_upd + 2'd1;
        else if (!update_taken_i && cnt_upd != 2'b00)
            cnt_upd = cnt_upd - 2'd1;
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni)
            valid_q <= '0;
        else if (update_valid_i)
            valid_q[wr_idx] <= 1'b1;
    end

    always_ff @(posedge clk_i) begin
        if (update_valid_i)
            cnt_q[wr_idx] <= cnt_upd;
    end

endmodule

//--- cf_predict.sv
/* taken decision and target for the responding word, from scan, BHT and RAS
   also drives RAS push and pop for accepted calls and returns */
module cf_predict (
    input  logic                      resp_valid_i,
    input  fetch_frontend_pkg::addr_t resp_pc_i,
    input  logic                      is_branch_i,
    input  logic                      is_jal_i,
    input  logic                      is_jalr_i,
    input  logic                      is_call_i,
    input  logic                      is_return_i,
    input  fetch_frontend_pkg::addr_t imm_i,
    input  logic                      bht_valid_i,
    input  logic                      bht_taken_i,
    input  logic                      ras_valid_i,
    input  fetch_frontend_pkg::addr_t ras_addr_i,
    input  logic                      accept_i,
    output logic                      predict_taken_o,
    output fetch_frontend_pkg::addr_t predict_target_o,
    output fetch_frontend_pkg::cf_e   cf_o,
    output logic                      ras_push_o,
    output logic                      ras_pop_o,
    output fetch_frontend_pkg::addr_t ras_push_addr_o
);

    fetch_frontend_pkg::addr_t seq_pc;
    logic                      branch_taken;

    assign seq_pc = resp_pc_i + fetch_frontend_pkg::INSTR_BYTES;

    // dynamic when the BHT knows the branch, else backward taken
    assign branch_taken = bht_valid_i ? bht_taken_i : imm_i[fetch_frontend_pkg::XLEN-1];

    always_comb begin
        predict_taken_o  = 1'b0;
        predict_target_o = seq_pc;
        cf_o             = fetch_frontend_pkg::CF_NONE;
        if (resp_valid_i) begin
            if (is_branch_i && branch_taken) begin
                predict_taken_o  = 1'b1;
                predict_target_o = resp_pc_i + imm_i;
                cf_o             = fetch_frontend_pkg::CF_BRANCH;
            end else if (is_jal_i) begin
                predict_taken_o  = 1'b1;
                predict_target_o = resp_pc_i + imm_i;
                cf_o             = fetch_frontend_pkg::CF_JUMP;
            end else if (is_return_i && ras_valid_i) begin
                predict_taken_o  = 1'b1;
                predict_target_o = ras_addr_i;
                cf_o             = fetch_frontend_pkg::CF_RETURN;
            end else if (is_jalr_i) begin
                // left to the back-end
                cf_o = fetch_frontend_pkg::CF_JALR;
            end
        end
    end

    // RAS changes only for words that made it into the queue
    assign ras_push_o      = accept_i & is_call_i;
    assign ras_pop_o       = accept_i & is_return_i & ras_valid_i;
    assign ras_push_addr_o = seq_pc;

endmodule

//--- fetch_frontend.f
fetch_frontend_pkg.sv
instr_scan.sv
bht.sv
ras.sv
cf_predict.sv
fetch_queue.sv
pc_gen.sv
fetch_frontend.sv
tb_fetch_frontend.sv

//--- fetch_frontend.sv
/* RV32I fetch frontend top: next-PC generation, scan, prediction and the
   entry queue towards the back-end */
module fetch_frontend #(
    parameter int unsigned BhtEntries = fetch_frontend_pkg::BHT_ENTRIES_DEF,
    parameter int unsigned RasDepth   = fetch_frontend_pkg::RAS_DEPTH_DEF,
    parameter int unsigned QueueDepth = fetch_frontend_pkg::QUEUE_DEPTH_DEF
) (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  fetch_frontend_pkg::addr_t  boot_addr_i,
    // memory side
    output logic                       fetch_req_o,
    output fetch_frontend_pkg::addr_t  fetch_addr_o,
    input  logic                       fetch_valid_i,
    input  fetch_frontend_pkg::instr_t fetch_data_i,
    // redirects
    input  logic                       mispredict_i,
    input  fetch_frontend_pkg::addr_t  mispredict_target_i,
    input  logic                       eret_i,
    input  fetch_frontend_pkg::addr_t  epc_i,
    input  logic                       ex_valid_i,
    input  fetch_frontend_pkg::addr_t  trap_vector_i,
    input  logic                       set_pc_commit_i,
    input  fetch_frontend_pkg::addr_t  pc_commit_i,
    // branch resolution
    input  logic                       resolve_valid_i,
    input  fetch_frontend_pkg::addr_t  resolve_pc_i,
    input  logic                       resolve_taken_i,
    // back-end side
    output logic                       fetch_valid_o,
    input  logic                       fetch_ready_i,
    output fetch_frontend_pkg::addr_t  fetch_pc_o,
    output fetch_frontend_pkg::instr_t fetch_instr_o,
    output fetch_frontend_pkg::cf_e    fetch_cf_o,
    output fetch_frontend_pkg::addr_t  fetch_target_o
);

    // response stage
    logic                      resp_valid;
    fetch_frontend_pkg::addr_t resp_pc;
    // scan results
    logic                      is_branch, is_jal, is_jalr, is_call, is_return;
    fetch_frontend_pkg::addr_t imm;
    // predictor state
    logic                      bht_valid, bht_taken;
    logic                      ras_valid, ras_push, ras_pop;
    fetch_frontend_pkg::addr_t ras_addr, ras_push_addr;
    // prediction result
    logic                      predict_taken;
    fetch_frontend_pkg::addr_t predict_target;
    fetch_frontend_pkg::cf_e   cf;
    // queue feedback
    logic                      accept, queue_ready, replay, flush;
    fetch_frontend_pkg::addr_t replay_addr;

    // every back-end redirect empties the queue
    assign flush = mispredict_i | eret_i | ex_valid_i | set_pc_commit_i;

    pc_gen i_pc_gen (
        .clk_i, .rst_ni, .boot_addr_i,
        .mispredict_i, .mispredict_target_i, .eret_i, .epc_i,
        .ex_valid_i, .trap_vector_i, .set_pc_commit_i, .pc_commit_i,
        .predict_taken_i  (predict_taken),
        .predict_target_i (predict_target),
        .queue_ready_i    (queue_ready),
        .replay_i         (replay),
        .replay_addr_i    (replay_addr),
        .fetch_valid_i,
        .fetch_req_o, .fetch_addr_o,
        .resp_valid_o     (resp_valid),
        .resp_pc_o        (resp_pc)
    );

    instr_scan i_instr_scan (
        .instr_i     (fetch_data_i),
        .is_branch_o (is_branch),
        .is_jal_o    (is_jal),
        .is_jalr_o   (is_jalr),
        .is_call_o   (is_call),
        .is_return_o (is_return),
        .imm_o       (imm)
    );

    // trained only by resolved conditional branches
    bht #(.BhtEntries(BhtEntries)) i_bht (
        .clk_i, .rst_ni,
        .pc_i           (resp_pc),
        .update_valid_i (resolve_valid_i),
        .update_pc_i    (resolve_pc_i),
        .update_taken_i (resolve_taken_i),
        .pred_valid_o   (bht_valid),
        .pred_taken_o   (bht_taken)
    );

    ras #(.RasDepth(RasDepth)) i_ras (
        .clk_i, .rst_ni,
        .push_i      (ras_push),
        .pop_i       (ras_pop),
        .push_addr_i (ras_push_addr),
        .top_valid_o (ras_valid),
        .top_addr_o  (ras_addr)
    );

    cf_predict i_cf_predict (
        .resp_valid_i (resp_valid), .resp_pc_i (resp_pc),
        .is_branch_i (is_branch), .is_jal_i (is_jal), .is_jalr_i (is_jalr),
        .is_call_i (is_call), .is_return_i (is_return), .imm_i (imm),
        .bht_valid_i (bht_valid), .bht_taken_i (bht_taken),
        .ras_valid_i (ras_valid), .ras_addr_i (ras_addr),
        .accept_i (accept),
        .predict_taken_o (predict_taken), .predict_target_o (predict_target),
        .cf_o (cf),
        .ras_push_o (ras_push), .ras_pop_o (ras_pop), .ras_push_addr_o (ras_push_addr)
    );

    fetch_queue #(.QueueDepth(QueueDepth)) i_fetch_queue (
        .clk_i, .rst_ni,
        .flush_i (flush), .valid_i (resp_valid), .pc_i (resp_pc),
        .instr_i (fetch_data_i), .cf_i (cf), .target_i (predict_target),
        .ready_i (fetch_ready_i),
        .accept_o (accept), .queue_ready_o (queue_ready),
        .replay_o (replay), .replay_addr_o (replay_addr),
        .valid_o (fetch_valid_o), .pc_o (fetch_pc_o), .instr_o (fetch_instr_o),
        .cf_o (fetch_cf_o), .target_o (fetch_target_o)
    );

endmodule

//--- fetch_frontend_pkg.sv
/* shared widths, opcodes and control-flow kinds of the RV32I fetch frontend
   every RTL file refers to these by scoped name */
package fetch_frontend_pkg;

    // ------------------------------
    // widths and types
    // ------------------------------
    localparam int unsigned XLEN = 32;

    typedef logic [XLEN-1:0] addr_t;
    typedef logic [31:0]     instr_t;

    // sequential fetch step, also the link offset of a call
    localparam addr_t INSTR_BYTES = 32'd4;

    // kind of control flow carried with a queue entry
    typedef enum logic [2:0] {
        CF_NONE   = 3'd0,
        CF_BRANCH = 3'd1,  // predicted taken branch
        CF_JUMP   = 3'd2,
        CF_RETURN = 3'd3,
        CF_JALR   = 3'd4   // target not predicted
    } cf_e;

    // ------------------------------
    // decode constants
    // ------------------------------
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

    // link registers per the calling convention
    localparam logic [4:0] REG_RA = 5'd1;
    localparam logic [4:0] REG_T0 = 5'd5;

    // default table and queue sizes
    localparam int unsigned BHT_ENTRIES_DEF = 16;
    localparam int unsigned RAS_DEPTH_DEF   = 4;
    localparam int unsigned QUEUE_DEPTH_DEF = 4;

endpackage

//--- fetch_queue.sv
/* circular FIFO of fetch entries towards the back-end
   a response that finds it full is dropped and replayed */
module fetch_queue #(
    parameter int unsigned QueueDepth = fetch_frontend_pkg::QUEUE_DEPTH_DEF
) (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  logic                       flush_i,
    input  logic                       valid_i,
    input  fetch_frontend_pkg::addr_t  pc_i,
    input  fetch_frontend_pkg::instr_t instr_i,
    input  fetch_frontend_pkg::cf_e    cf_i,
    input  fetch_frontend_pkg::addr_t  target_i,
    input  logic                       ready_i,
    output logic                       accept_o,
    output logic                       queue_ready_o,
    output logic                       replay_o,
    output fetch_frontend_pkg::addr_t  replay_addr_o,
    output logic                       valid_o,
    output fetch_frontend_pkg::addr_t  pc_o,
    output fetch_frontend_pkg::instr_t instr_o,
    output fetch_frontend_pkg::cf_e    cf_o,
    output fetch_frontend_pkg::addr_t  target_o
);

    localparam int unsigned PtrW = (QueueDepth > 1) ? $clog2(QueueDepth) : 1;
    localparam int unsigned CntW = $clog2(QueueDepth + 1);

    fetch_frontend_pkg::addr_t  pc_q     [QueueDepth];
    fetch_frontend_pkg::instr_t instr_q  [QueueDepth];
    fetch_frontend_pkg::cf_e    cf_q     [QueueDepth];
    fetch_frontend_pkg::addr_t  target_q [QueueDepth];
    logic [PtrW-1:0]            wptr_q, rptr_q;
    logic [CntW-1:0]            count_q;
    logic                       full, push, pop;

    assign full = (count_q == CntW'(QueueDepth));
    assign push = valid_i & ~flush_i & ~full;
    assign pop  = valid_o & ready_i;

    assign accept_o      = push;
    assign queue_ready_o = ~full;
    // replay the word that found no room
    assign replay_o      = valid_i & ~flush_i & full;
    assign replay_addr_o = pc_i;

    // nothing leaves while the back-end redirects
    assign valid_o  = (count_q != '0) & ~flush_i;
    assign pc_o     = pc_q[rptr_q];
    assign instr_o  = instr_q[rptr_q];
    assign cf_o     = cf_q[rptr_q];
    assign target_o = target_q[rptr_q];

    // ------------------------------
    // pointers and fill level
    // ------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wptr_q  <= '0;
            rptr_q  <= '0;
            count_q <= '0;
        end else if (flush_i) begin
            wptr_q  <= '0;
            rptr_q  <= '0;
            count_q <= '0;
        end else begin
            if (push)
                wptr_q <= (wptr_q == PtrW'(QueueDepth - 1)) ? '0 : wptr_q + 1'b1;
            if (pop)
                rptr_q <= (rptr_q == PtrW'(QueueDepth - 1)) ? '0 : rptr_q + 1'b1;
            count_q <= count_q + CntW'(push) - CntW'(pop);
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            pc_q[wptr_q]     <= pc_i;
            instr_q[wptr_q]  <= instr_i;
            cf_q[wptr_q]     <= cf_i;
            target_q[wptr_q] <= target_i;
        end
    end

endmodule

//--- instr_scan.sv
/* combinational RV32I scan of one fetched word for control flow,
   with the sign-extended branch or jump offset */
module instr_scan (
    input  fetch_frontend_pkg::instr_t instr_i,
    output logic                       is_branch_o,
    output logic                       is_jal_o,
    output logic                       is_jalr_o,
    output logic                       is_call_o,
    output logic                       is_return_o,
    output fetch_frontend_pkg::addr_t  imm_o
);

    logic [6:0]                opcode;
    logic [4:0]                rd, rs1;
    logic                      rd_link, rs1_link;
    fetch_frontend_pkg::addr_t b_imm, j_imm;

    assign opcode = instr_i[6:0];
    assign rd     = instr_i[11:7];
    assign rs1    = instr_i[19:15];

    // ra and t0 both count as link registers
    assign rd_link  = (rd == fetch_frontend_pkg::REG_RA) | (rd == fetch_frontend_pkg::REG_T0);
    assign rs1_link = (rs1 == fetch_frontend_pkg::REG_RA) | (rs1 == fetch_frontend_pkg::REG_T0);

    assign is_branch_o = (opcode == fetch_frontend_pkg::OPC_BRANCH);
    assign is_jal_o    = (opcode == fetch_frontend_pkg::OPC_JAL);
    assign is_jalr_o   = (opcode == fetch_frontend_pkg::OPC_JALR);

    // call links, return reads a link register without writing one
    assign is_call_o   = (is_jal_o | is_jalr_o) & rd_link;
    assign is_return_o = is_jalr_o & rs1_link & ~rd_link;

    // B-type offset
    assign b_imm = {{(fetch_frontend_pkg::XLEN-12){instr_i[31]}},
                    instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
    // J-type offset
    assign j_imm = {{(fetch_frontend_pkg::XLEN-20){instr_i[31]}},
                    instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};

    assign imm_o = is_branch_o ? b_imm : j_imm;

endmodule

//--- pc_gen.sv
/* next-PC register with redirect precedence, plus the response-stage PC
   and kill flag for the one-cycle memory */
module pc_gen (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  fetch_frontend_pkg::addr_t boot_addr_i,
    input  logic                      mispredict_i,
    input  fetch_frontend_pkg::addr_t mispredict_target_i,
    input  logic                      eret_i,
    input  fetch_frontend_pkg::addr_t epc_i,
    input  logic                      ex_valid_i,
    input  fetch_frontend_pkg::addr_t trap_vector_i,
    input  logic                      set_pc_commit_i,
    input  fetch_frontend_pkg::addr_t pc_commit_i,
    input  logic                      predict_taken_i,
    input  fetch_frontend_pkg::addr_t predict_target_i,
    input  logic                      queue_ready_i,
    input  logic                      replay_i,
    input  fetch_frontend_pkg::addr_t replay_addr_i,
    input  logic                      fetch_valid_i,
    output logic                      fetch_req_o,
    output fetch_frontend_pkg::addr_t fetch_addr_o,
    output logic                      resp_valid_o,
    output fetch_frontend_pkg::addr_t resp_pc_o
);

    fetch_frontend_pkg::addr_t npc_d, npc_q;
    fetch_frontend_pkg::addr_t resp_pc_q;
    // set during reset, loads the boot address once
    logic                      npc_rst_load_q;
    // kills the response of the request issued last cycle
    logic                      kill_q;
    logic                      redirect;

    assign redirect = mispredict_i | eret_i | ex_valid_i | set_pc_commit_i;

    assign fetch_addr_o = npc_rst_load_q ? boot_addr_i : npc_q;
    // boot load cycle issues nothing
    assign fetch_req_o  = queue_ready_i & ~npc_rst_load_q;

    // ------------------------------
    // next PC, later wins
    // ------------------------------
    always_comb begin
        npc_d = fetch_addr_o;
        if (fetch_req_o)
            npc_d = fetch_addr_o + fetch_frontend_pkg::INSTR_BYTES;
        if (predict_taken_i)
            npc_d = predict_target_i;
        if (replay_i)
            npc_d = replay_addr_i;
        if (mispredict_i)
            npc_d = mispredict_target_i;
        if (eret_i)
            npc_d = epc_i;
        if (ex_valid_i)
            npc_d = trap_vector_i;
        // refetch after the instruction in commit
        if (set_pc_commit_i)
            npc_d = pc_commit_i + fetch_frontend_pkg::INSTR_BYTES;
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            npc_rst_load_q <= 1'b1;
            npc_q          <= '0;
            kill_q         <= 1'b0;
        end else begin
            npc_rst_load_q <= 1'b0;
            npc_q          <= npc_d;
            // a taken prediction discards the sequential request behind it
            kill_q         <= redirect | replay_i | predict_taken_i;
        end
    end

    // address of the request now in memory
    always_ff @(posedge clk_i) begin
        if (fetch_req_o)
            resp_pc_q <= fetch_addr_o;
    end

    assign resp_valid_o = fetch_valid_i & ~kill_q & ~redirect;
    assign resp_pc_o    = resp_pc_q;

endmodule

//--- ras.sv
/* return address stack, entry 0 is the top
   a push on a full stack drops the oldest address */
module ras #(
    parameter int unsigned RasDepth = fetch_frontend_pkg::RAS_DEPTH_DEF
) (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  logic                      push_i,
    input  logic                      pop_i,
    input  fetch_frontend_pkg::addr_t push_addr_i,
    output logic                      top_valid_o,
    output fetch_frontend_pkg::addr_t top_addr_o
);

    fetch_frontend_pkg::addr_t addr_q [RasDepth];
    logic [RasDepth-1:0]       valid_q;

    assign top_valid_o = valid_q[0];
    assign top_addr_o  = addr_q[0];

    // push and pop together replace the top
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni)
            valid_q <= '0;
        else if (push_i && pop_i)
            valid_q[0] <= 1'b1;
        else if (push_i)
            valid_q <= {valid_q[RasDepth-2:0], 1'b1};
        else if (pop_i)
            valid_q <= {1'b0, valid_q[RasDepth-1:1]};
    end

    always_ff @(posedge clk_i) begin
        if (push_i && !pop_i) begin
            // older entries move down one slot
            for (int i = RasDepth - 1; i > 0; i--)
                addr_q[i] <= addr_q[i-1];
        end else if (pop_i && !push_i) begin
            for (int i = 0; i < RasDepth - 1; i++)
                addr_q[i] <= addr_q[i+1];
        end
        if (push_i)
            addr_q[0] <= push_addr_i;
    end

endmodule

//--- run.sh
#!/bin/sh
# build with Verilator and run, pass only when the testbench reports no errors
verilator --binary --top-module tb_fetch_frontend -f fetch_frontend.f -o sim_fetch_frontend \
    && ./obj_dir/sim_fetch_frontend | grep -q "No errors" \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }

//--- tb_fetch_frontend.sv
/* testbench for the RV32I fetch frontend with a one-cycle memory model,
   a scenario table of redirects and expected entries, and LFSR back-pressure */
module tb_fetch_frontend;

    localparam fetch_frontend_pkg::addr_t  BOOT_ADDR     = 32'h0000_1000;
    localparam fetch_frontend_pkg::instr_t NOP           = 32'h0000_0013;
    localparam int                         MEM_WORDS     = 64;
    localparam int                         ENTRY_TIMEOUT = 100;

    typedef struct {
        string                     name;
        logic [3:0]                redir;  // commit, trap, eret, mispredict
        fetch_frontend_pkg::addr_t misp, epc, trap, commit;
        logic                      res;
        fetch_frontend_pkg::addr_t res_pc;
        logic                      lfsr;
        int                        first;
        int                        count;
    } scen_t;

    logic                       clk_i, rst_ni;
    fetch_frontend_pkg::addr_t  boot_addr_i;
    logic                       fetch_req_o, fetch_valid_i;
    fetch_frontend_pkg::addr_t  fetch_addr_o;
    fetch_frontend_pkg::instr_t fetch_data_i;
    logic                       mispredict_i, eret_i, ex_valid_i, set_pc_commit_i;
    fetch_frontend_pkg::addr_t  mispredict_target_i, epc_i, trap_vector_i, pc_commit_i;
    logic                       resolve_valid_i, resolve_taken_i;
    fetch_frontend_pkg::addr_t  resolve_pc_i;
    logic                       fetch_valid_o, fetch_ready_i;
    fetch_frontend_pkg::addr_t  fetch_pc_o, fetch_target_o;
    fetch_frontend_pkg::instr_t fetch_instr_o;
    fetch_frontend_pkg::cf_e    fetch_cf_o;

    fetch_frontend_pkg::instr_t prog_mem [MEM_WORDS];
    // request seen this cycle and answered in the next one
    logic                       pend_req;
    fetch_frontend_pkg::addr_t  pend_addr;
    logic [31:0]                lfsr_q;
    scen_t                      scen_q [$];
    fetch_frontend_pkg::addr_t  exp_pc [$];
    fetch_frontend_pkg::cf_e    exp_cf [$];
    fetch_frontend_pkg::addr_t  exp_tgt [$];

    fetch_frontend i_fetch_frontend (.*);

    always #50 clk_i = ~clk_i;

    // ------------------------------
    // ISA encoders and memory
    // ------------------------------
    function automatic fetch_frontend_pkg::instr_t enc_branch(input int off);
        logic [12:0] o;
        o = 13'(off);
        // beq x0, x0, off
        return {o[12], o[10:5], 5'd0, 5'd0, 3'b000, o[4:1], o[11], 7'b1100011};
    endfunction

    function automatic fetch_frontend_pkg::instr_t enc_jal(input logic [4:0] rd, input int off);
        logic [20:0] o;
        o = 21'(off);
        return {o[20], o[10:1], o[11], o[19:12], rd, 7'b1101111};
    endfunction

    function automatic fetch_frontend_pkg::instr_t enc_jalr(input logic [4:0] rd,
                                                             input logic [4:0] rs1);
        return {12'd0, rs1, 3'b000, rd, 7'b1100111};
    endfunction

    // addi-class filler whose upper bits fold in the whole address
    function automatic fetch_frontend_pkg::instr_t fill_word(input fetch_frontend_pkg::addr_t a);
        return {a[31:7] ^ {18'd0, a[6:0]}, 7'b0010011};
    endfunction

    // nop outside the program window
    function automatic fetch_frontend_pkg::instr_t mem_word(input fetch_frontend_pkg::addr_t a);
        fetch_frontend_pkg::addr_t ofs;
        ofs = a - BOOT_ADDR;
        if (ofs < 32'(MEM_WORDS * 4))
            return prog_mem[ofs[7:2]];
        return NOP;
    endfunction

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // ------------------------------
    // reporting and compare
    // ------------------------------
    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic check_addr(input string name, input fetch_frontend_pkg::addr_t exp,
                              input fetch_frontend_pkg::addr_t act);
        if (exp !== act)
            fail_now($sformatf("ERR %s expected %h actual %h", name, exp, act));
    endtask

    task automatic check_instr(input string name, input fetch_frontend_pkg::instr_t exp,
                               input fetch_frontend_pkg::instr_t act);
        if (exp !== act)
            fail_now($sformatf("ERR %s expected %h actual %h", name, exp, act));
    endtask

    task automatic check_cf(input string name, input fetch_frontend_pkg::cf_e exp,
                            input fetch_frontend_pkg::cf_e act);
        if (exp !== act)
            fail_now($sformatf("ERR %s expected %s actual %s", name, exp.name(), act.name()));
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act)
            fail_now($sformatf("ERR %s expected %b actual %b", name, exp, act));
    endtask

    // answers the request of the previous cycle and notes the new one
    task automatic step();
        @(negedge clk_i);
        fetch_valid_i = pend_req;
        fetch_data_i  = mem_word(pend_addr);
        pend_req      = (fetch_req_o === 1'b1);
        pend_addr     = fetch_addr_o;
    endtask

    // ------------------------------
    // scenario table
    // ------------------------------
    task automatic add_exp(input fetch_frontend_pkg::addr_t pc, input fetch_frontend_pkg::cf_e cf,
                           input fetch_frontend_pkg::addr_t tgt);
        exp_pc.push_back(pc);
        exp_cf.push_back(cf);
        exp_tgt.push_back(tgt);
    endtask

    task automatic add_scen(input string name, input logic [3:0] redir,
                            input fetch_frontend_pkg::addr_t misp,
                            input fetch_frontend_pkg::addr_t epc,
                            input fetch_frontend_pkg::addr_t trap,
                            input fetch_frontend_pkg::addr_t commit,
                            input logic res, input fetch_frontend_pkg::addr_t res_pc,
                            input logic lfsr, input int first);
        scen_t s;
        s.name   = name;
        s.redir  = redir;
        s.misp   = misp;
        s.epc    = epc;
        s.trap   = trap;
        s.commit = commit;
        s.res    = res;
        s.res_pc = res_pc;
        s.lfsr   = lfsr;
        s.first  = first;
        s.count  = exp_pc.size() - first;
        scen_q.push_back(s);
    endtask

    task automatic load_table();
        int first;
        // straight line from boot
        first = exp_pc.size();
        for (int i = 0; i < 4; i++)
            add_exp(BOOT_ADDR + 32'(4 * i), fetch_frontend_pkg::CF_NONE,
                    BOOT_ADDR + 32'(4 * i + 4));
        add_scen("seq_fetch", 4'b0000, '0, '0, '0, '0, 1'b0, '0, 1'b0, first);
        // forward branch falls through and backward branch loops
        first = exp_pc.size();
        add_exp(32'h1040, fetch_frontend_pkg::CF_NONE, 32'h1044);
        add_exp(32'h1044, fetch_frontend_pkg::CF_NONE, 32'h1048);
        add_exp(32'h1048, fetch_frontend_pkg::CF_NONE, 32'h104C);
        add_exp(32'h104C, fetch_frontend_pkg::CF_BRANCH, 32'h1040);
        add_exp(32'h1040, fetch_frontend_pkg::CF_NONE, 32'h1044);
        add_scen("static_pred", 4'b0001, 32'h1040, '0, '0, '0, 1'b0, '0, 1'b0, first);
        // call then return through the RAS
        first = exp_pc.size();
        add_exp(32'h1080, fetch_frontend_pkg::CF_JUMP, 32'h10A0);
        add_exp(32'h10A0, fetch_frontend_pkg::CF_NONE, 32'h10A4);
        add_exp(32'h10A4, fetch_frontend_pkg::CF_RETURN, 32'h1084);
        add_exp(32'h1084, fetch_frontend_pkg::CF_NONE, 32'h1088);
        add_scen("call_return", 4'b0010, '0, 32'h1080, '0, '0, 1'b0, '0, 1'b0, first);
        // trained forward branch now taken
        first = exp_pc.size();
        add_exp(32'h1044, fetch_frontend_pkg::CF_BRANCH, 32'h1054);
        add_exp(32'h1054, fetch_frontend_pkg::CF_NONE, 32'h1058);
        add_scen("bht_train", 4'b0100, '0, '0, 32'h1044, '0, 1'b1, 32'h1044, 1'b0, first);
        // commit wins over all others
        first = exp_pc.size();
        for (int i = 0; i < 3; i++)
            add_exp(32'h10C4 + 32'(4 * i), fetch_frontend_pkg::CF_NONE, 32'h10C8 + 32'(4 * i));
        add_scen("redir_prio", 4'b1111, 32'h1040, 32'h1080, 32'h1044, 32'h10C0,
                 1'b0, '0, 1'b0, first);
        // long stream under random ready
        first = exp_pc.size();
        for (int i = 0; i < 12; i++)
            add_exp(32'h10E0 + 32'(4 * i), fetch_frontend_pkg::CF_NONE, 32'h10E4 + 32'(4 * i));
        add_scen("back_pressure", 4'b1000, '0, '0, '0, 32'h10DC, 1'b0, '0, 1'b1, first);
    endtask

    task automatic run_scenario(input scen_t sc);
        int   k;
        int   waited;
        logic rdy;
        step();
        fetch_ready_i = 1'b0;
        if (sc.res) begin
            resolve_valid_i = 1'b1;
            resolve_pc_i    = sc.res_pc;
            resolve_taken_i = 1'b1;
            step();
            resolve_valid_i = 1'b0;
        end
        if (sc.redir != 4'b0000) begin
            mispredict_i        = sc.redir[0];
            mispredict_target_i = sc.misp;
            eret_i              = sc.redir[1];
            epc_i               = sc.epc;
            ex_valid_i          = sc.redir[2];
            trap_vector_i       = sc.trap;
            set_pc_commit_i     = sc.redir[3];
            pc_commit_i         = sc.commit;
            step();
            {set_pc_commit_i, ex_valid_i, eret_i, mispredict_i} = 4'b0000;
        end
        k      = 0;
        waited = 0;
        while (k < sc.count) begin
            step();
            if (sc.lfsr) begin
                lfsr_q = lfsr_next(lfsr_q);
                rdy    = lfsr_q[0];
            end else begin
                rdy = 1'b1;
            end
            fetch_ready_i = rdy;
            // this entry transfers at the coming rising edge
            if (fetch_valid_o && rdy) begin
                check_addr($sformatf("%s[%0d] pc", sc.name, k), exp_pc[sc.first + k], fetch_pc_o);
                check_instr($sformatf("%s[%0d] instr", sc.name, k),
                            mem_word(exp_pc[sc.first + k]), fetch_instr_o);
                check_cf($sformatf("%s[%0d] cf", sc.name, k), exp_cf[sc.first + k], fetch_cf_o);
                check_addr($sformatf("%s[%0d] target", sc.name, k),
                           exp_tgt[sc.first + k], fetch_target_o);
                k++;
                waited = 0;
            end else begin
                waited++;
                if (waited > ENTRY_TIMEOUT)
                    fail_now($sformatf("%s timed out waiting for entry %0d", sc.name, k));
            end
        end
    endtask

    initial begin
        clk_i               = 1'b0;
        rst_ni              = 1'b0;
        boot_addr_i         = BOOT_ADDR;
        fetch_valid_i       = 1'b0;
        fetch_data_i        = NOP;
        {mispredict_i, eret_i, ex_valid_i, set_pc_commit_i} = 4'b0000;
        mispredict_target_i = '0;
        epc_i               = '0;
        trap_vector_i       = '0;
        pc_commit_i         = '0;
        resolve_valid_i     = 1'b0;
        resolve_taken_i     = 1'b0;
        resolve_pc_i        = '0;
        fetch_ready_i       = 1'b0;
        pend_req            = 1'b0;
        pend_addr           = '0;
        lfsr_q              = 32'h1b52_eefd;
        for (int i = 0; i < MEM_WORDS; i++)
            prog_mem[i] = fill_word(BOOT_ADDR + 32'(4 * i));
        prog_mem[17] = enc_branch(16);
        prog_mem[19] = enc_branch(-12);
        prog_mem[32] = enc_jal(5'd1, 32'h20);
        prog_mem[41] = enc_jalr(5'd0, 5'd1);
        load_table();
        repeat (4) step();
        rst_ni = 1'b1;
        // boot load cycle
        check_bit("reset fetch_req", 1'b0, fetch_req_o);
        check_bit("reset fetch_valid", 1'b0, fetch_valid_o);
        check_addr("boot fetch_addr", BOOT_ADDR, fetch_addr_o);
        foreach (scen_q[i])
            run_scenario(scen_q[i]);
        $display("No errors");
        $finish;
    end

endmodule
